// File: hdl/bramArray_cfg.svh
// Geometry macros of the dual-port memory array and of its 32-bit cells
`ifndef BRAM_ARRAY_CFG_SVH
`define BRAM_ARRAY_CFG_SVH

// Array as seen from the ports

// Width of one array word in bits
`define BRAM_ARR_DATA_BITW 64

// Number of array words over all banks
`define BRAM_ARR_ENTRIES 2048

// Byte address width, one bit wider than the array needs so overflow exists
`define BRAM_ARR_ADDR_BITW 15

// One behavioral memory cell

// Width of a cell word in bits
`define BRAM_CELL_BITW 32

// Depth of a cell in words
`define BRAM_CELL_WORDS 1024

`endif

// File: hdl/bramCellPkg.sv
// Package with the data, byte-enable and word-index types of one memory cell
`include "bramArray_cfg.svh"

package bramCellPkg;

  // Data word stored in one cell
  typedef logic [`BRAM_CELL_BITW-1:0] cellWordT;

  // One write enable per cell byte
  typedef logic [`BRAM_CELL_BITW/8-1:0] cellByteEnT;

  // Word index inside a cell
  typedef logic [$clog2(`BRAM_CELL_WORDS)-1:0] cellIdxT;

endpackage

// File: hdl/bramArrayPkg.sv
// Package with the array geometry counts, the port data types and the request struct
`include "bramArray_cfg.svh"

package bramArrayPkg;

  // Cells side by side to build one array word
  localparam int numParCells = `BRAM_ARR_DATA_BITW / `BRAM_CELL_BITW;

  // Cell rows stacked to reach the array depth
  localparam int numSerCells = `BRAM_ARR_ENTRIES / `BRAM_CELL_WORDS;

  // Low address bits that select a byte inside an array word
  localparam int wordOffsetBits = $clog2(`BRAM_ARR_DATA_BITW / 8);

  // Full array word
  typedef logic [`BRAM_ARR_DATA_BITW-1:0] arrWordT;

  // Byte enables of a full array word
  typedef logic [`BRAM_ARR_DATA_BITW/8-1:0] arrByteEnT;

  // Byte address presented by a port
  typedef logic [`BRAM_ARR_ADDR_BITW-1:0] byteAddrT;

  // Index of a cell row
  typedef logic [$clog2(numSerCells)-1:0] bankIdxT;

  // One-hot row select, all zero when the address overflows
  typedef logic [numSerCells-1:0] bankSelT;

  // One port request, taken on every edge where en is set
  typedef struct packed {
    logic      en;
    arrByteEnT wrEn;
    byteAddrT  addr;
    arrWordT   wrData;
  } bramReqT;

endpackage

// File: hdl/bramAddrDecode.sv
// Byte address decoder giving cell word index, bank index and one-hot bank select
`timescale 1ns/100ps
`include "bramArray_cfg.svh"

module bramAddrDecode (
  input  bramArrayPkg::byteAddrT addr,
  output bramCellPkg::cellIdxT   cellIdx,
  output bramArrayPkg::bankIdxT  bankIdx,
  output bramArrayPkg::bankSelT  bankSel
);

  localparam int IdxBits      = $bits(bramCellPkg::cellIdxT);
  localparam int WordAddrBits = `BRAM_ARR_ADDR_BITW - bramArrayPkg::wordOffsetBits;
  localparam int BankRawBits  = WordAddrBits - IdxBits;

  logic [WordAddrBits-1:0] wordAddr;
  logic [BankRawBits-1:0]  bankRaw;
  logic                    overflow;

  // Byte offset bits are dropped, accesses are word aligned
  assign wordAddr = addr[`BRAM_ARR_ADDR_BITW-1:bramArrayPkg::wordOffsetBits];

  // Low part picks the word inside a cell, high part picks the row
  assign cellIdx = wordAddr[IdxBits-1:0];
  assign bankRaw = wordAddr[WordAddrBits-1:IdxBits];

  // Rows beyond the array count as overflow
  assign overflow = (bankRaw >= BankRawBits'(bramArrayPkg::numSerCells));

  // Overflowed accesses fall back to row 0 for reading
  assign bankIdx = overflow ? '0 : bramArrayPkg::bankIdxT'(bankRaw);

  always_comb begin
    for (int s = 0; s < bramArrayPkg::numSerCells; s++) begin
      bankSel[s] = !overflow && (bankRaw == BankRawBits'(s));
    end
  end

endmodule

// File: hdl/bramCell.sv
// Behavioral true dual-port cell with byte enables, write-first and registered read data
`timescale 1ns/100ps
`include "bramArray_cfg.svh"

module bramCell (
  input  logic                    A_PS,
  input  logic                    arstN,
  input  logic                    enA,
  input  logic                    enB,
  input  bramCellPkg::cellByteEnT wrEnA,
  input  bramCellPkg::cellByteEnT wrEnB,
  input  bramCellPkg::cellIdxT    idxA,
  input  bramCellPkg::cellIdxT    idxB,
  input  bramCellPkg::cellWordT   wrDataA,
  input  bramCellPkg::cellWordT   wrDataB,
  output bramCellPkg::cellWordT   rdDataA,
  output bramCellPkg::cellWordT   rdDataB
);

  localparam int CellBytes = $bits(bramCellPkg::cellByteEnT);

  bramCellPkg::cellWordT mem [0:`BRAM_CELL_WORDS-1];
  bramCellPkg::cellWordT mergedA;
  bramCellPkg::cellWordT mergedB;

  // Stored word with the enabled bytes replaced by new data
  function automatic bramCellPkg::cellWordT mergeBytes(
    bramCellPkg::cellWordT   oldWord,
    bramCellPkg::cellWordT   newWord,
    bramCellPkg::cellByteEnT byteEn
  );
    bramCellPkg::cellWordT res;
    res = oldWord;
    for (int b = 0; b < CellBytes; b++) begin
      if (byteEn[b]) res[b*8 +: 8] = newWord[b*8 +: 8];
    end
    return res;
  endfunction

  // Write-first, so a port reads back what it writes in the same cycle
  assign mergedA = mergeBytes(mem[idxA], wrDataA, wrEnA);
  assign mergedB = mergeBytes(mem[idxB], wrDataB, wrEnB);

  // Byte-wise writes keep disjoint bytes of both ports in the same word
  always_ff @(posedge A_PS) begin
    for (int b = 0; b < CellBytes; b++) begin
      if (enA && wrEnA[b]) mem[idxA][b*8 +: 8] <= wrDataA[b*8 +: 8];
      if (enB && wrEnB[b]) mem[idxB][b*8 +: 8] <= wrDataB[b*8 +: 8];
    end
  end

  // Read registers hold while the port is idle
  always_ff @(posedge A_PS or negedge arstN) begin
    if (!arstN) begin
      rdDataA <= '0;
      rdDataB <= '0;
    end else begin
      if (enA) rdDataA <= mergedA;
      if (enB) rdDataB <= mergedB;
    end
  end

endmodule

// File: hdl/tdpBramArray.sv
// Top level dual-port array with address decoders, cell grid and registered bank mux
`timescale 1ns/100ps

module tdpBramArray (
  input  logic                   A_PS,
  input  logic                   arstN,
  input  bramArrayPkg::bramReqT  reqA,
  input  bramArrayPkg::bramReqT  reqB,
  output bramArrayPkg::arrWordT  rdDataA,
  output bramArrayPkg::arrWordT  rdDataB
);

  localparam int CellBits  = $bits(bramCellPkg::cellWordT);
  localparam int CellBytes = $bits(bramCellPkg::cellByteEnT);

  bramCellPkg::cellIdxT  cellIdxA;
  bramCellPkg::cellIdxT  cellIdxB;
  bramArrayPkg::bankIdxT bankIdxA;
  bramArrayPkg::bankIdxT bankIdxB;
  bramArrayPkg::bankSelT bankSelA;
  bramArrayPkg::bankSelT bankSelB;

  // Row index of the read in flight, used by the output mux
  bramArrayPkg::bankIdxT bankIdxAReg;
  bramArrayPkg::bankIdxT bankIdxBReg;

  // Cell outputs, one row concatenated per entry, column 0 in the low lane
  bramCellPkg::cellWordT [bramArrayPkg::numSerCells-1:0][bramArrayPkg::numParCells-1:0] cellRdA;
  bramCellPkg::cellWordT [bramArrayPkg::numSerCells-1:0][bramArrayPkg::numParCells-1:0] cellRdB;

  bramAddrDecode decA0 (
    .addr    (reqA.addr),
    .cellIdx (cellIdxA),
    .bankIdx (bankIdxA),
    .bankSel (bankSelA)
  );

  bramAddrDecode decB0 (
    .addr    (reqB.addr),
    .cellIdx (cellIdxB),
    .bankIdx (bankIdxB),
    .bankSel (bankSelB)
  );

  for (genvar s = 0; s < bramArrayPkg::numSerCells; s++) begin : gRow
    logic                   rowEnA;
    logic                   rowEnB;
    bramArrayPkg::arrByteEnT rowWrEnA;
    bramArrayPkg::arrByteEnT rowWrEnB;

    // Reads follow bankIdx so an overflow reads row 0; writes need a valid bank
    assign rowEnA   = reqA.en && (bankIdxA == bramArrayPkg::bankIdxT'(s));
    assign rowEnB   = reqB.en && (bankIdxB == bramArrayPkg::bankIdxT'(s));
    assign rowWrEnA = (reqA.en && bankSelA[s]) ? reqA.wrEn : '0;
    assign rowWrEnB = (reqB.en && bankSelB[s]) ? reqB.wrEn : '0;

    for (genvar p = 0; p < bramArrayPkg::numParCells; p++) begin : gCol
      bramCell cell0 (
        .A_PS    (A_PS),
        .arstN   (arstN),
        .enA     (rowEnA),
        .enB     (rowEnB),
        .wrEnA   (rowWrEnA[p*CellBytes +: CellBytes]),
        .wrEnB   (rowWrEnB[p*CellBytes +: CellBytes]),
        .idxA    (cellIdxA),
        .idxB    (cellIdxB),
        .wrDataA (reqA.wrData[p*CellBits +: CellBits]),
        .wrDataB (reqB.wrData[p*CellBits +: CellBits]),
        .rdDataA (cellRdA[s][p]),
        .rdDataB (cellRdB[s][p])
      );
    end
  end

  // Bank index travels alongside the read so back-to-back reads pick the right row
  always_ff @(posedge A_PS or negedge arstN) begin
    if (!arstN) begin
      bankIdxAReg <= '0;
      bankIdxBReg <= '0;
    end else begin
      if (reqA.en) bankIdxAReg <= bankIdxA;
      if (reqB.en) bankIdxBReg <= bankIdxB;
    end
  end

  assign rdDataA = cellRdA[bankIdxAReg];
  assign rdDataB = cellRdB[bankIdxBReg];

endmodule

// File: tb/tdpBramArray_asserts.sv
// Concurrent assertions on reset read data, overflow write gating and port write overlap
`timescale 1ns/100ps

module tdpBramArrayAsserts (
  input logic                                                    A_PS,
  input logic                                                    arstN,
  input bramArrayPkg::bramReqT                                   reqA,
  input bramArrayPkg::bramReqT                                   reqB,
  input bramArrayPkg::arrByteEnT [bramArrayPkg::numSerCells-1:0] rowWrEnA,
  input bramArrayPkg::arrByteEnT [bramArrayPkg::numSerCells-1:0] rowWrEnB,
  input bramArrayPkg::arrWordT                                   rdDataA,
  input bramArrayPkg::arrWordT                                   rdDataB
);

  localparam int BankLsb = bramArrayPkg::wordOffsetBits + $bits(bramCellPkg::cellIdxT);

  logic ovfA;
  logic ovfB;
  int   wordA;
  int   wordB;

  // Bank field beyond the last cell row
  assign ovfA  = int'(reqA.addr >> BankLsb) >= bramArrayPkg::numSerCells;
  assign ovfB  = int'(reqB.addr >> BankLsb) >= bramArrayPkg::numSerCells;
  assign wordA = int'(reqA.addr >> bramArrayPkg::wordOffsetBits);
  assign wordB = int'(reqB.addr >> bramArrayPkg::wordOffsetBits);

  assert property (@(posedge A_PS) !arstN |-> (rdDataA == '0) && (rdDataB == '0))
    else $error("Read data not zero while reset is asserted");

  // Byte enables as the cells see them, all rows together
  assert property (@(posedge A_PS) disable iff (!arstN) (reqA.en && ovfA) |-> rowWrEnA == '0)
    else $error("Overflow request on port A reaches a cell write enable");

  assert property (@(posedge A_PS) disable iff (!arstN) (reqB.en && ovfB) |-> rowWrEnB == '0)
    else $error("Overflow request on port B reaches a cell write enable");

  assert property (@(posedge A_PS) disable iff (!arstN)
    (reqA.en && reqB.en && !ovfA && !ovfB && wordA == wordB) |-> (reqA.wrEn & reqB.wrEn) == '0)
    else $error("Both ports write the same bytes of one word in one cycle");

endmodule

bind tdpBramArray tdpBramArrayAsserts asserts0 (
  .A_PS     (A_PS),
  .arstN    (arstN),
  .reqA     (reqA),
  .reqB     (reqB),
  .rowWrEnA ({gRow[1].rowWrEnA, gRow[0].rowWrEnA}),
  .rowWrEnB ({gRow[1].rowWrEnB, gRow[0].rowWrEnB}),
  .rdDataA  (rdDataA),
  .rdDataB  (rdDataB)
);

// File: tb/tdpBramArrayTb.sv
// Testbench for the dual-port memory array with reference model, directed tests and timeout
`timescale 1ns/100ps

module tdpBramArrayTb;

  localparam int CellWords     = 1024;
  localparam int WordBytes     = 8;
  localparam int ResetCycles   = 5;
  localparam int RandCycles    = 200;
  localparam int PoolBase      = 512;
  localparam int PoolSize      = 16;
  // Limit well above the few hundred cycles the tests take
  localparam int TimeoutCycles = 3000;
  // Byte-enable patterns covering both cell columns, 8 bits each
  localparam logic [39:0] BePatterns = 40'h0f_f0_3c_80_01;

  logic                  A_PS = 1'b0;
  logic                  arstN;
  bramArrayPkg::bramReqT reqA;
  bramArrayPkg::bramReqT reqB;
  bramArrayPkg::arrWordT rdDataA;
  bramArrayPkg::arrWordT rdDataB;

  // Expected memory contents keyed by word address
  bramArrayPkg::arrWordT model [int];
  int unsigned           errCount = 0;
  int unsigned           cycleCount = 0;
  int unsigned           seedDummy;

  tdpBramArray dut0 (
    .A_PS    (A_PS),
    .arstN   (arstN),
    .reqA    (reqA),
    .reqB    (reqB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  always #5 A_PS = ~A_PS;

  always @(posedge A_PS) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      errCount = errCount + 1;
      $display("Errors: %0d", errCount);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic checkVal(input string testName, input bramArrayPkg::arrWordT expected,
                          input bramArrayPkg::arrWordT actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s: expected %h, actual %h", testName, expected, actual);
      errCount = errCount + 1;
    end
  endtask

  function automatic bramArrayPkg::byteAddrT mkAddr(input int bank, input int idx);
    return bramArrayPkg::byteAddrT'((bank * CellWords + idx) * WordBytes);
  endfunction

  function automatic bramArrayPkg::arrWordT randWord();
    return {$urandom, $urandom};
  endfunction

  function automatic bramArrayPkg::bramReqT wrReq(input bramArrayPkg::byteAddrT addr,
                                                  input bramArrayPkg::arrByteEnT be,
                                                  input bramArrayPkg::arrWordT data);
    bramArrayPkg::bramReqT r;
    r.en     = 1'b1;
    r.wrEn   = be;
    r.addr   = addr;
    r.wrData = data;
    return r;
  endfunction

  function automatic bramArrayPkg::bramReqT rdReq(input bramArrayPkg::byteAddrT addr);
    return wrReq(addr, '0, '0);
  endfunction

  // Applies one request to the model and returns the word the port must read back
  function automatic bramArrayPkg::arrWordT applyToModel(input bramArrayPkg::bramReqT r);
    int                    wordAddr;
    bramArrayPkg::arrWordT word;
    wordAddr = int'(r.addr) / WordBytes;
    // Banks 2 and 3 do not exist, reads fall back to bank 0 and writes are lost
    if (wordAddr / CellWords >= 2) begin
      return model[wordAddr % CellWords];
    end
    word = model.exists(wordAddr) ? model[wordAddr] : '0;
    for (int b = 0; b < WordBytes; b++) begin
      if (r.wrEn[b]) word[b*8 +: 8] = r.wrData[b*8 +: 8];
    end
    if (r.wrEn != '0) model[wordAddr] = word;
    return word;
  endfunction

  // One request per port, taken at the next edge, read data sampled mid-cycle after it
  task automatic runCycle(input bramArrayPkg::bramReqT a, input bramArrayPkg::bramReqT b);
    @(posedge A_PS);
    reqA <= a;
    reqB <= b;
    @(posedge A_PS);
    reqA <= '0;
    reqB <= '0;
    @(negedge A_PS);
  endtask

  task automatic testFullWord();
    bramArrayPkg::bramReqT r;
    bramArrayPkg::arrWordT exp;
    for (int bank = 0; bank < 2; bank++) begin
      for (int k = 0; k < 3; k++) begin
        r = wrReq(mkAddr(bank, 3 + k * 300), 8'hff, randWord());
        exp = applyToModel(r);
        runCycle(r, '0);
        checkVal("fullWordWrite", exp, rdDataA);
        r = rdReq(mkAddr(bank, 3 + k * 300));
        exp = applyToModel(r);
        runCycle(r, '0);
        checkVal("fullWordRead", exp, rdDataA);
      end
    end
  endtask

  task automatic testByteEnables();
    bramArrayPkg::bramReqT r;
    bramArrayPkg::arrWordT exp;
    for (int bank = 0; bank < 2; bank++) begin
      for (int k = 0; k < 5; k++) begin
        r = wrReq(mkAddr(bank, 303), BePatterns[k*8 +: 8], randWord());
        exp = applyToModel(r);
        runCycle(r, '0);
        checkVal("byteEnableWrite", exp, rdDataA);
        r = rdReq(mkAddr(bank, 303));
        exp = applyToModel(r);
        runCycle('0, r);
        checkVal("byteEnableRead", exp, rdDataB);
      end
    end
  endtask

  task automatic testCrossPort();
    bramArrayPkg::bramReqT r;
    bramArrayPkg::arrWordT exp;
    for (int bank = 0; bank < 2; bank++) begin
      r = wrReq(mkAddr(bank, 700), 8'hff, randWord());
      exp = applyToModel(r);
      runCycle(r, '0);
      checkVal("crossPortWriteA", exp, rdDataA);
      r = rdReq(mkAddr(bank, 700));
      exp = applyToModel(r);
      runCycle('0, r);
      checkVal("crossPortAtoB", exp, rdDataB);
      r = wrReq(mkAddr(bank, 701), 8'hff, randWord());
      exp = applyToModel(r);
      runCycle('0, r);
      checkVal("crossPortWriteB", exp, rdDataB);
      r = rdReq(mkAddr(bank, 701));
      exp = applyToModel(r);
      runCycle(r, '0);
      checkVal("crossPortBtoA", exp, rdDataA);
    end
  endtask

  task automatic testWriteFirst();
    bramArrayPkg::bramReqT a;
    bramArrayPkg::bramReqT b;
    bramArrayPkg::arrWordT expA;
    bramArrayPkg::arrWordT expB;
    // Both ports write partial words in different banks in the same cycle
    a = wrReq(mkAddr(0, 603), 8'h5a, randWord());
    b = wrReq(mkAddr(1, 603), 8'ha5, randWord());
    expA = applyToModel(a);
    expB = applyToModel(b);
    runCycle(a, b);
    checkVal("writeFirstA", expA, rdDataA);
    checkVal("writeFirstB", expB, rdDataB);
  endtask

  task automatic testOverflow();
    bramArrayPkg::bramReqT a;
    bramArrayPkg::bramReqT b;
    bramArrayPkg::arrWordT expA;
    bramArrayPkg::arrWordT expB;
    a = wrReq(mkAddr(2, 3), 8'hff, randWord());
    b = wrReq(mkAddr(3, 603), 8'hff, randWord());
    expA = applyToModel(a);
    expB = applyToModel(b);
    runCycle(a, b);
    checkVal("overflowWriteA", expA, rdDataA);
    checkVal("overflowWriteB", expB, rdDataB);
    // Bank 0 must still hold its old words
    a = rdReq(mkAddr(0, 3));
    b = rdReq(mkAddr(0, 603));
    expA = applyToModel(a);
    expB = applyToModel(b);
    runCycle(a, b);
    checkVal("overflowBank0A", expA, rdDataA);
    checkVal("overflowBank0B", expB, rdDataB);
  endtask

  function automatic bramArrayPkg::bramReqT randReq(input int bank);
    bramArrayPkg::byteAddrT addr;
    addr = mkAddr(bank, PoolBase + int'($urandom % PoolSize));
    if ($urandom % 2 == 0) return rdReq(addr);
    return wrReq(addr, bramArrayPkg::arrByteEnT'($urandom), randWord());
  endfunction

  task automatic testRandomTraffic();
    bramArrayPkg::bramReqT a;
    bramArrayPkg::bramReqT b;
    bramArrayPkg::arrWordT expA;
    bramArrayPkg::arrWordT expB;
    bramArrayPkg::arrWordT prevA;
    bramArrayPkg::arrWordT prevB;
    // Fill the address pool so every random read hits a written word
    for (int k = 0; k < PoolSize; k++) begin
      a = wrReq(mkAddr(0, PoolBase + k), 8'hff, randWord());
      b = wrReq(mkAddr(1, PoolBase + k), 8'hff, randWord());
      expA = applyToModel(a);
      expB = applyToModel(b);
      runCycle(a, b);
      checkVal("poolFillA", expA, rdDataA);
      checkVal("poolFillB", expB, rdDataB);
    end
    // Ports alternate banks and never share one, a new request every cycle
    for (int i = 0; i < RandCycles; i++) begin
      a = randReq(i % 2);
      b = randReq(1 - i % 2);
      @(posedge A_PS);
      reqA <= a;
      reqB <= b;
      expA = applyToModel(a);
      expB = applyToModel(b);
      @(negedge A_PS);
      if (i > 0) begin
        checkVal("randomA", prevA, rdDataA);
        checkVal("randomB", prevB, rdDataB);
      end
      prevA = expA;
      prevB = expB;
    end
    @(posedge A_PS);
    reqA <= '0;
    reqB <= '0;
    @(negedge A_PS);
    checkVal("randomA", prevA, rdDataA);
    checkVal("randomB", prevB, rdDataB);
  endtask

  initial begin
    reqA <= '0;
    reqB <= '0;
    arstN <= 1'b0;
    seedDummy = $urandom(32'hf934_d818);
    repeat (ResetCycles) @(posedge A_PS);
    arstN <= 1'b1;
    @(negedge A_PS);
    checkVal("resetValueA", '0, rdDataA);
    checkVal("resetValueB", '0, rdDataB);
    testFullWord();
    testByteEnables();
    testCrossPort();
    testWriteFirst();
    testOverflow();
    testRandomTraffic();
    $display("Errors: %0d", errCount);
    if (errCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+hdl
hdl/bramCellPkg.sv
hdl/bramArrayPkg.sv
hdl/bramAddrDecode.sv
hdl/bramCell.sv
hdl/tdpBramArray.sv
tb/tdpBramArray_asserts.sv
tb/tdpBramArrayTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and search the log for the fail message
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --timescale 1ns/100ps --top-module tdpBramArrayTb \
  -f list.f -o tdpBramArraySim \
  && ./obj_dir/tdpBramArraySim | tee sim.log \
  || { echo "Build or simulation run did not complete"; exit 1; }

grep -qF '*** FAILED ***' sim.log && { echo "Simulation reported errors"; exit 1; } || exit 0
